// File: Makefile
TOP := wasm_cpu_tb
LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove build output and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -f vlog.f --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "TEST RESULT: PASS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: test/wasm_cpu_chk.sv
`timescale 1ns/100ps

module wasm_cpu_chk (
  input logic                        clk,
  input logic                        reset,
  input wasm_core_pkg::stack_entry_t result,
  input logic                        result_empty,
  input wasm_isa_pkg::trap_t         trap
);

  trap_cleared: assert property (@(posedge clk) reset |=> trap == wasm_isa_pkg::TRAP_NONE)
    else $error("trap not cleared after reset");

  // Core stays frozen once trapped
  trap_sticky: assert property (@(posedge clk)
    (!reset && trap != wasm_isa_pkg::TRAP_NONE) |=> trap == $past(trap))
    else $error("trap changed without reset");

  i32_zero_ext: assert property (@(posedge clk) disable iff (reset)
    result.tag == wasm_isa_pkg::I32 |-> result.value[63:32] == 32'd0)
    else $error("i32 result has nonzero upper half");

  // Stack untouched until reset once trapped
  stack_frozen: assert property (@(posedge clk)
    (!reset && trap != wasm_isa_pkg::TRAP_NONE) |=> $stable(result) && $stable(result_empty))
    else $error("stack changed while trapped");

endmodule

bind wasm_cpu wasm_cpu_chk chk_i (
  .clk          (clk),
  .reset        (reset),
  .result       (result),
  .result_empty (result_empty),
  .trap         (trap)
);

// File: test/wasm_cpu_tb.sv
`timescale 1ns/100ps

module wasm_cpu_tb;

  localparam int CLK_PERIOD   = 8;
  localparam int RESET_CYCLES = 8;
  // Seventeen two-byte pushes need more than 16 bytes
  localparam int MAX_BYTES    = 40;
  localparam int ROW_CYCLES   = RESET_CYCLES + MAX_BYTES + MAX_BYTES * 3;

  typedef struct packed {
    wasm_core_pkg::rom_byte_t [MAX_BYTES-1:0] bytes;
    logic [5:0]                               length;
    wasm_core_pkg::pc_t                       start_pc;
    wasm_isa_pkg::trap_t                      trap;
    logic                                     empty;
    wasm_core_pkg::stack_entry_t              entry;
  } test_row_t;

  logic                        clk;
  logic                        reset;
  wasm_core_pkg::pc_t          start_pc;
  logic                        prog_we;
  wasm_core_pkg::pc_t          prog_addr;
  wasm_core_pkg::rom_byte_t    prog_data;
  wasm_core_pkg::stack_entry_t result;
  logic                        result_empty;
  wasm_isa_pkg::trap_t         trap;

  test_row_t   rows[$];
  test_row_t   cur;
  logic        table_ready;
  logic [31:0] lcg_state;

  wasm_cpu dut_i (
    .clk          (clk),
    .reset        (reset),
    .start_pc     (start_pc),
    .prog_we      (prog_we),
    .prog_addr    (prog_addr),
    .prog_data    (prog_data),
    .result       (result),
    .result_empty (result_empty),
    .trap         (trap)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  task automatic fail_run(input int row);
    $display("TEST RESULT: FAIL");
    $fatal(1, "Stopped at row %0d", row);
  endtask

  task automatic check_trap(input int row, input wasm_isa_pkg::trap_t got,
                            input wasm_isa_pkg::trap_t expected);
    if (got !== expected) begin
      $display("[FAIL] row %0d trap: got %h, expected %h", row, got, expected);
      fail_run(row);
    end
  endtask

  task automatic check_entry(input int row, input wasm_core_pkg::stack_entry_t got,
                             input wasm_core_pkg::stack_entry_t expected);
    if (got !== expected) begin
      $display("[FAIL] row %0d result: got tag %h value %h, expected tag %h value %h",
               row, got.tag, got.value, expected.tag, expected.value);
      fail_run(row);
    end
  endtask

  task automatic check_empty(input int row, input logic got, input logic expected);
    if (got !== expected) begin
      $display("[FAIL] row %0d result_empty: got %h, expected %h", row, got, expected);
      fail_run(row);
    end
  endtask

  task automatic begin_row(input wasm_core_pkg::pc_t pc);
    cur          = '0;
    cur.start_pc = pc;
  endtask

  task automatic emit(input wasm_core_pkg::rom_byte_t b);
    cur.bytes[cur.length] = b;
    cur.length            = cur.length + 6'd1;
  endtask

  // Signed LEB128, last byte once the rest is pure sign
  task automatic emit_const(input wasm_isa_pkg::opcode_t op, input logic signed [63:0] v);
    logic signed [63:0] rest;
    logic [7:0]         b;
    logic               done;
    emit(op);
    rest = v;
    done = 1'b0;
    while (!done) begin
      b    = {1'b0, rest[6:0]};
      rest = rest >>> 7;
      done = (rest == '0 && !b[6]) || (rest == '1 && b[6]);
      if (!done) begin
        b[7] = 1'b1;
      end
      emit(b);
    end
  endtask

  task automatic end_row(input wasm_isa_pkg::trap_t t, input logic empty,
                         input wasm_isa_pkg::value_type_t tag, input wasm_core_pkg::value_t v);
    cur.trap        = t;
    cur.empty       = empty;
    cur.entry.tag   = tag;
    cur.entry.value = v;
    rows.push_back(cur);
  endtask

  task automatic binary_row(input wasm_isa_pkg::opcode_t cop, input logic signed [63:0] a,
                            input logic signed [63:0] b, input wasm_isa_pkg::opcode_t op,
                            input wasm_isa_pkg::value_type_t tag,
                            input wasm_core_pkg::value_t expected);
    begin_row(8'd0);
    emit_const(cop, a);
    emit_const(cop, b);
    emit(op);
    emit(wasm_isa_pkg::OP_END);
    end_row(wasm_isa_pkg::TRAP_ENDED, 1'b0, tag, expected);
  endtask

  // Load during reset, then run until the core traps
  task automatic run_row(input test_row_t row);
    int cycles;
    @(negedge clk);
    reset    = 1'b1;
    start_pc = row.start_pc;
    cycles   = 0;
    while (cycles < RESET_CYCLES || cycles < row.length) begin
      prog_we = cycles < row.length;
      if (cycles < row.length) begin
        prog_addr = row.start_pc + wasm_core_pkg::pc_t'(cycles);
        prog_data = row.bytes[cycles];
      end
      @(negedge clk);
      cycles++;
    end
    prog_we = 1'b0;
    reset   = 1'b0;
    while (trap == wasm_isa_pkg::TRAP_NONE) begin
      @(negedge clk);
    end
  endtask

  initial begin : watchdog
    wait (table_ready);
    #(2 * rows.size() * ROW_CYCLES * CLK_PERIOD);
    $display("Watchdog expired before all rows finished");
    fail_run(-1);
  end

  initial begin : main
    logic [31:0] a32;
    logic [31:0] b32;
    logic [63:0] a64;
    logic [63:0] b64;
    reset       = 1'b1;
    start_pc    = '0;
    prog_we     = 1'b0;
    prog_addr   = '0;
    prog_data   = '0;
    table_ready = 1'b0;
    lcg_state   = 32'd32066;

    // Constants, with a nop and a moved start address
    begin_row(8'd0);
    emit(wasm_isa_pkg::OP_NOP);
    emit_const(wasm_isa_pkg::OP_I32_CONST, 64'sd624485);
    emit(wasm_isa_pkg::OP_END);
    end_row(wasm_isa_pkg::TRAP_ENDED, 1'b0, wasm_isa_pkg::I32, 64'h9_8765);
    begin_row(8'd0);
    emit_const(wasm_isa_pkg::OP_I64_CONST, -64'sd123456789012);
    emit(wasm_isa_pkg::OP_END);
    end_row(wasm_isa_pkg::TRAP_ENDED, 1'b0, wasm_isa_pkg::I64, -64'sd123456789012);
    begin_row(8'd20);
    emit_const(wasm_isa_pkg::OP_I32_CONST, -64'sd2);
    emit(wasm_isa_pkg::OP_END);
    end_row(wasm_isa_pkg::TRAP_ENDED, 1'b0, wasm_isa_pkg::I32, 64'hFFFF_FFFE);

    // Arithmetic, sub is second minus top
    binary_row(wasm_isa_pkg::OP_I32_CONST, -64'sd1, 64'sd5, wasm_isa_pkg::OP_I32_ADD,
               wasm_isa_pkg::I32, 64'd4);
    binary_row(wasm_isa_pkg::OP_I32_CONST, 64'sd3, 64'sd10, wasm_isa_pkg::OP_I32_SUB,
               wasm_isa_pkg::I32, 64'hFFFF_FFF9);
    binary_row(wasm_isa_pkg::OP_I64_CONST, 64'sh1_0000_0000, -64'sd1, wasm_isa_pkg::OP_I64_ADD,
               wasm_isa_pkg::I64, 64'hFFFF_FFFF);
    binary_row(wasm_isa_pkg::OP_I64_CONST, 64'sd1000, 64'sd1, wasm_isa_pkg::OP_I64_SUB,
               wasm_isa_pkg::I64, 64'd999);

    // Comparisons give i32 flags
    binary_row(wasm_isa_pkg::OP_I32_CONST, 64'sd7, 64'sd7, wasm_isa_pkg::OP_I32_EQ,
               wasm_isa_pkg::I32, 64'd1);
    binary_row(wasm_isa_pkg::OP_I32_CONST, 64'sd7, 64'sd8, wasm_isa_pkg::OP_I32_NE,
               wasm_isa_pkg::I32, 64'd1);
    binary_row(wasm_isa_pkg::OP_I64_CONST, 64'sd5, 64'sd6, wasm_isa_pkg::OP_I64_EQ,
               wasm_isa_pkg::I32, 64'd0);
    binary_row(wasm_isa_pkg::OP_I64_CONST, 64'sd5, 64'sd5, wasm_isa_pkg::OP_I64_NE,
               wasm_isa_pkg::I32, 64'd0);
    begin_row(8'd0);
    emit_const(wasm_isa_pkg::OP_I32_CONST, 64'sd0);
    emit(wasm_isa_pkg::OP_I32_EQZ);
    emit(wasm_isa_pkg::OP_END);
    end_row(wasm_isa_pkg::TRAP_ENDED, 1'b0, wasm_isa_pkg::I32, 64'd1);
    begin_row(8'd0);
    emit_const(wasm_isa_pkg::OP_I64_CONST, 64'sd9);
    emit(wasm_isa_pkg::OP_I64_EQZ);
    emit(wasm_isa_pkg::OP_END);
    end_row(wasm_isa_pkg::TRAP_ENDED, 1'b0, wasm_isa_pkg::I32, 64'd0);
    begin_row(8'd0);
    emit_const(wasm_isa_pkg::OP_I32_CONST, 64'sd1);
    emit(wasm_isa_pkg::OP_DROP);
    emit(wasm_isa_pkg::OP_END);
    end_row(wasm_isa_pkg::TRAP_ENDED, 1'b1, wasm_isa_pkg::I32, 64'd0);

    // select: val1, val2, condition
    for (int c = 0; c < 3; c++) begin
      begin_row(8'd0);
      emit_const((c == 2) ? wasm_isa_pkg::OP_I32_CONST : wasm_isa_pkg::OP_I64_CONST, 64'sd11);
      emit_const(wasm_isa_pkg::OP_I64_CONST, 64'sd22);
      emit_const(wasm_isa_pkg::OP_I32_CONST, (c == 1) ? 64'sd0 : 64'sd1);
      emit(wasm_isa_pkg::OP_SELECT);
      emit(wasm_isa_pkg::OP_END);
      if (c == 2) begin
        end_row(wasm_isa_pkg::TRAP_TYPES_MISMATCH, 1'b0, wasm_isa_pkg::I32, 64'd1);
      end else begin
        end_row(wasm_isa_pkg::TRAP_ENDED, 1'b0, wasm_isa_pkg::I64, (c == 1) ? 64'd22 : 64'd11);
      end
    end

    // Traps
    begin_row(8'd0);
    emit(wasm_isa_pkg::OP_UNREACHABLE);
    end_row(wasm_isa_pkg::TRAP_UNREACHABLE, 1'b1, wasm_isa_pkg::I32, 64'd0);
    begin_row(8'd0);
    emit_const(wasm_isa_pkg::OP_I32_CONST, 64'sd5);
    emit(8'hFF);
    end_row(wasm_isa_pkg::TRAP_UNKNOWN_OPCODE, 1'b0, wasm_isa_pkg::I32, 64'd5);
    begin_row(8'd0);
    emit_const(wasm_isa_pkg::OP_I64_CONST, 64'sd1);
    emit_const(wasm_isa_pkg::OP_I32_CONST, 64'sd2);
    emit(wasm_isa_pkg::OP_I32_ADD);
    end_row(wasm_isa_pkg::TRAP_TYPE_MISMATCH, 1'b0, wasm_isa_pkg::I32, 64'd2);
    begin_row(8'd0);
    emit(wasm_isa_pkg::OP_DROP);
    end_row(wasm_isa_pkg::TRAP_STACK_EMPTY, 1'b1, wasm_isa_pkg::I32, 64'd0);
    begin_row(8'd0);
    for (int k = 1; k <= 17; k++) begin
      emit_const(wasm_isa_pkg::OP_I32_CONST, 64'(k));
    end
    end_row(wasm_isa_pkg::TRAP_STACK_FULL, 1'b0, wasm_isa_pkg::I32, 64'd16);
    begin_row(8'd64);
    end_row(wasm_isa_pkg::TRAP_ROM_ERROR, 1'b1, wasm_isa_pkg::I32, 64'd0);

    // Random operands, i32.add and i64.sub in turn
    for (int r = 0; r < 4; r++) begin
      if (r % 2 == 0) begin
        a32 = lcg_next();
        b32 = lcg_next();
        binary_row(wasm_isa_pkg::OP_I32_CONST, {{32{a32[31]}}, a32}, {{32{b32[31]}}, b32},
                   wasm_isa_pkg::OP_I32_ADD, wasm_isa_pkg::I32, {32'd0, a32 + b32});
      end else begin
        a64[63:32] = lcg_next();
        a64[31:0]  = lcg_next();
        b64[63:32] = lcg_next();
        b64[31:0]  = lcg_next();
        binary_row(wasm_isa_pkg::OP_I64_CONST, a64, b64, wasm_isa_pkg::OP_I64_SUB,
                   wasm_isa_pkg::I64, a64 - b64);
      end
    end
    table_ready = 1'b1;

    foreach (rows[i]) begin
      run_row(rows[i]);
      check_trap(i, trap, rows[i].trap);
      check_empty(i, result_empty, rows[i].empty);
      check_entry(i, result, rows[i].entry);
    end
    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule

// File: verilog/leb128_decoder.sv
`timescale 1ns/100ps

module leb128_decoder (
  input  wasm_core_pkg::rom_byte_t [wasm_isa_pkg::LEB128_MAX_BYTES-1:0] bytes,
  output wasm_core_pkg::value_t                                         value,
  output logic [3:0]                                                    length
);

  always_comb begin : decode
    logic done;

    done   = 1'b0;
    value  = '0;
    // Unterminated immediates count as the longest form
    length = 4'(wasm_isa_pkg::LEB128_MAX_BYTES);

    for (int i = 0; i < wasm_isa_pkg::LEB128_MAX_BYTES; i++) begin
      if (!done) begin
        // Little-endian 7-bit groups
        value = value | (wasm_core_pkg::value_t'(bytes[i][6:0]) << (7 * i));

        if (!bytes[i][7]) begin
          done   = 1'b1;
          length = 4'(i + 1);
          // Sign bit is bit 6 of the last byte; shift of 70 leaves nothing
          if (bytes[i][6]) begin
            value = value | ({64{1'b1}} << (7 * (i + 1)));
          end
        end
      end
    end
  end

endmodule

// File: verilog/program_rom.sv
`timescale 1ns/100ps

module program_rom (
  input  logic                       clk,
  input  logic                       prog_we,
  input  wasm_core_pkg::pc_t         prog_addr,
  input  wasm_core_pkg::rom_byte_t   prog_data,
  input  wasm_core_pkg::pc_t         rom_addr,
  output wasm_core_pkg::rom_window_t window,
  output logic                       rom_error
);

  typedef logic [$clog2(wasm_core_pkg::ROM_DEPTH)-1:0] rom_index_t;

  wasm_core_pkg::rom_byte_t mem [wasm_core_pkg::ROM_DEPTH];

  // Bytes past the end of memory read as zero
  function automatic wasm_core_pkg::rom_byte_t read_byte(input logic [8:0] addr);
    if (addr < wasm_core_pkg::ROM_DEPTH) begin
      return mem[rom_index_t'(addr)];
    end
    return '0;
  endfunction

  // Load port, writes outside the memory are ignored
  always_ff @(posedge clk) begin
    if (prog_we && prog_addr < wasm_core_pkg::ROM_DEPTH) begin
      mem[rom_index_t'(prog_addr)] <= prog_data;
    end
  end

  // Registered window, valid one cycle after rom_addr
  always_ff @(posedge clk) begin
    window.opcode <= read_byte(9'(rom_addr));
    for (int i = 0; i < wasm_isa_pkg::LEB128_MAX_BYTES; i++) begin
      window.imm[i] <= read_byte(9'(rom_addr) + 9'(i + 1));
    end
    rom_error <= rom_addr >= wasm_core_pkg::ROM_DEPTH;
  end

endmodule

// File: verilog/value_stack.sv
`timescale 1ns/100ps

module value_stack (
  input  logic                        clk,
  input  logic                        reset,
  input  wasm_core_pkg::stack_op_t    op,
  input  wasm_core_pkg::stack_entry_t data,
  output wasm_core_pkg::stack_entry_t top,
  output wasm_core_pkg::stack_entry_t second,
  output wasm_core_pkg::stack_entry_t third,
  output wasm_core_pkg::stack_count_t count
);

  typedef logic [$clog2(wasm_core_pkg::STACK_DEPTH)-1:0] stack_index_t;

  wasm_core_pkg::stack_entry_t entries [wasm_core_pkg::STACK_DEPTH];

  stack_index_t                idx1;
  stack_index_t                idx2;
  stack_index_t                idx3;
  stack_index_t                wr_idx;
  logic                        wr_en;
  wasm_core_pkg::stack_count_t next_count;

  // Positions of the three entries nearest the top
  assign idx1 = stack_index_t'(count - 5'd1);
  assign idx2 = stack_index_t'(count - 5'd2);
  assign idx3 = stack_index_t'(count - 5'd3);

  assign top    = (count > 5'd0) ? entries[idx1] : '0;
  assign second = (count > 5'd1) ? entries[idx2] : '0;
  assign third  = (count > 5'd2) ? entries[idx3] : '0;

  // Control never pushes a full stack or pops past the bottom
  always_comb begin
    wr_en      = 1'b0;
    wr_idx     = idx1;
    next_count = count;
    case (op)
      wasm_core_pkg::STACK_PUSH: begin
        wr_en      = 1'b1;
        wr_idx     = stack_index_t'(count);
        next_count = count + 5'd1;
      end
      wasm_core_pkg::STACK_POP: begin
        next_count = count - 5'd1;
      end
      wasm_core_pkg::STACK_REPLACE: begin
        wr_en = 1'b1;
      end
      wasm_core_pkg::STACK_POP1_REPLACE: begin
        wr_en      = 1'b1;
        wr_idx     = idx2;
        next_count = count - 5'd1;
      end
      wasm_core_pkg::STACK_POP2_REPLACE: begin
        wr_en      = 1'b1;
        wr_idx     = idx3;
        next_count = count - 5'd2;
      end
      default: ;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      count <= '0;
    end else begin
      count <= next_count;
    end
  end

  always_ff @(posedge clk) begin
    if (wr_en) begin
      entries[wr_idx] <= data;
    end
  end

endmodule

// File: verilog/wasm_alu.sv
`timescale 1ns/100ps

module wasm_alu (
  input  wasm_isa_pkg::opcode_t       opcode,
  input  wasm_core_pkg::stack_entry_t top,
  input  wasm_core_pkg::stack_entry_t second,
  input  wasm_core_pkg::stack_entry_t third,
  output wasm_core_pkg::stack_entry_t result,
  output logic                        type_error,
  output logic                        select_error
);

  logic        top_is_i32;
  logic        pair_is_i32;
  logic        pair_is_i64;
  logic [31:0] add32;
  logic [31:0] sub32;

  assign top_is_i32  = top.tag == wasm_isa_pkg::I32;
  assign pair_is_i32 = top_is_i32 && second.tag == wasm_isa_pkg::I32;
  assign pair_is_i64 = top.tag == wasm_isa_pkg::I64 && second.tag == wasm_isa_pkg::I64;

  // Second is the left operand
  assign add32 = second.value[31:0] + top.value[31:0];
  assign sub32 = second.value[31:0] - top.value[31:0];

  always_comb begin
    type_error   = 1'b0;
    select_error = 1'b0;
    // Comparisons give an i32 flag
    result.tag   = wasm_isa_pkg::I32;
    result.value = '0;
    case (opcode)
      wasm_isa_pkg::OP_I32_EQZ: begin
        type_error   = !top_is_i32;
        result.value = wasm_core_pkg::value_t'(top.value[31:0] == 32'd0);
      end
      wasm_isa_pkg::OP_I64_EQZ: begin
        type_error   = top.tag != wasm_isa_pkg::I64;
        result.value = wasm_core_pkg::value_t'(top.value == 64'd0);
      end
      wasm_isa_pkg::OP_I32_EQ, wasm_isa_pkg::OP_I32_NE: begin
        type_error   = !pair_is_i32;
        result.value = wasm_core_pkg::value_t'((second.value[31:0] == top.value[31:0]) ^
                                               (opcode == wasm_isa_pkg::OP_I32_NE));
      end
      wasm_isa_pkg::OP_I64_EQ, wasm_isa_pkg::OP_I64_NE: begin
        type_error   = !pair_is_i64;
        result.value = wasm_core_pkg::value_t'((second.value == top.value) ^
                                               (opcode == wasm_isa_pkg::OP_I64_NE));
      end
      wasm_isa_pkg::OP_I32_ADD: begin
        type_error   = !pair_is_i32;
        result.value = {32'd0, add32};
      end
      wasm_isa_pkg::OP_I32_SUB: begin
        type_error   = !pair_is_i32;
        result.value = {32'd0, sub32};
      end
      wasm_isa_pkg::OP_I64_ADD: begin
        type_error   = !pair_is_i64;
        result.tag   = wasm_isa_pkg::I64;
        result.value = second.value + top.value;
      end
      wasm_isa_pkg::OP_I64_SUB: begin
        type_error   = !pair_is_i64;
        result.tag   = wasm_isa_pkg::I64;
        result.value = second.value - top.value;
      end
      wasm_isa_pkg::OP_SELECT: begin
        // Top is the condition, third is val1, second is val2
        type_error   = !top_is_i32;
        select_error = third.tag != second.tag;
        result       = (top.value[31:0] != 32'd0) ? third : second;
      end
      default: ;
    endcase
  end

endmodule

// File: verilog/wasm_control.sv
`timescale 1ns/100ps

module wasm_control (
  input  logic                        clk,
  input  logic                        reset,
  input  wasm_core_pkg::pc_t          start_pc,
  output wasm_core_pkg::pc_t          rom_addr,
  input  wasm_core_pkg::rom_window_t  window,
  input  logic                        rom_error,
  output wasm_core_pkg::stack_op_t    stack_op,
  output wasm_core_pkg::stack_entry_t stack_data,
  input  wasm_core_pkg::stack_entry_t top,
  input  wasm_core_pkg::stack_entry_t second,
  input  wasm_core_pkg::stack_entry_t third,
  input  wasm_core_pkg::stack_count_t count,
  output wasm_isa_pkg::trap_t         trap
);

  wasm_core_pkg::step_t        step;
  wasm_core_pkg::pc_t          pc;
  wasm_isa_pkg::opcode_t       opcode;
  wasm_core_pkg::value_t       imm_value;
  logic [3:0]                  imm_length;
  wasm_core_pkg::stack_entry_t alu_result;
  logic                        alu_type_error;
  logic                        alu_select_error;

  // Decoded instruction
  logic                        known;
  logic                        pushes;
  wasm_core_pkg::stack_count_t needed;
  wasm_core_pkg::stack_op_t    dec_op;
  wasm_core_pkg::stack_entry_t dec_data;
  logic [3:0]                  advance;
  wasm_isa_pkg::trap_t         op_trap;
  wasm_isa_pkg::trap_t         exec_trap;

  assign opcode = wasm_isa_pkg::opcode_t'(window.opcode);

  leb128_decoder leb128_i (
    .bytes  (window.imm),
    .value  (imm_value),
    .length (imm_length)
  );

  wasm_alu alu_i (
    .opcode       (opcode),
    .top          (top),
    .second       (second),
    .third        (third),
    .result       (alu_result),
    .type_error   (alu_type_error),
    .select_error (alu_select_error)
  );

  always_comb begin
    known    = 1'b1;
    pushes   = 1'b0;
    needed   = '0;
    dec_op   = wasm_core_pkg::STACK_NONE;
    dec_data = alu_result;
    advance  = '0;
    op_trap  = wasm_isa_pkg::TRAP_NONE;
    case (opcode)
      wasm_isa_pkg::OP_UNREACHABLE: op_trap = wasm_isa_pkg::TRAP_UNREACHABLE;
      wasm_isa_pkg::OP_END:         op_trap = wasm_isa_pkg::TRAP_ENDED;
      wasm_isa_pkg::OP_NOP: ;
      wasm_isa_pkg::OP_DROP: begin
        needed = 5'd1;
        dec_op = wasm_core_pkg::STACK_POP;
      end
      wasm_isa_pkg::OP_SELECT: begin
        needed = 5'd3;
        dec_op = wasm_core_pkg::STACK_POP2_REPLACE;
      end
      wasm_isa_pkg::OP_I32_CONST, wasm_isa_pkg::OP_I64_CONST: begin
        pushes  = 1'b1;
        dec_op  = wasm_core_pkg::STACK_PUSH;
        advance = imm_length;
        if (opcode == wasm_isa_pkg::OP_I32_CONST) begin
          dec_data.tag   = wasm_isa_pkg::I32;
          dec_data.value = {32'd0, imm_value[31:0]};
        end else begin
          dec_data.tag   = wasm_isa_pkg::I64;
          dec_data.value = imm_value;
        end
      end
      wasm_isa_pkg::OP_I32_EQZ, wasm_isa_pkg::OP_I64_EQZ: begin
        needed = 5'd1;
        dec_op = wasm_core_pkg::STACK_REPLACE;
      end
      wasm_isa_pkg::OP_I32_EQ, wasm_isa_pkg::OP_I32_NE,
      wasm_isa_pkg::OP_I64_EQ, wasm_isa_pkg::OP_I64_NE,
      wasm_isa_pkg::OP_I32_ADD, wasm_isa_pkg::OP_I32_SUB,
      wasm_isa_pkg::OP_I64_ADD, wasm_isa_pkg::OP_I64_SUB: begin
        needed = 5'd2;
        dec_op = wasm_core_pkg::STACK_POP1_REPLACE;
      end
      default: known = 1'b0;
    endcase
  end

  // Trap priority: memory, opcode, depth, operand types
  always_comb begin
    if (rom_error) begin
      exec_trap = wasm_isa_pkg::TRAP_ROM_ERROR;
    end else if (!known) begin
      exec_trap = wasm_isa_pkg::TRAP_UNKNOWN_OPCODE;
    end else if (count < needed) begin
      exec_trap = wasm_isa_pkg::TRAP_STACK_EMPTY;
    end else if (pushes &&
                 count == wasm_core_pkg::stack_count_t'(wasm_core_pkg::STACK_DEPTH)) begin
      exec_trap = wasm_isa_pkg::TRAP_STACK_FULL;
    end else if (alu_type_error) begin
      exec_trap = wasm_isa_pkg::TRAP_TYPE_MISMATCH;
    end else if (alu_select_error) begin
      exec_trap = wasm_isa_pkg::TRAP_TYPES_MISMATCH;
    end else begin
      exec_trap = op_trap;
    end
  end

  // Stack changes at the edge that ends EXEC, never once trapped
  assign stack_op = (step == wasm_core_pkg::EXEC && trap == wasm_isa_pkg::TRAP_NONE &&
                     exec_trap == wasm_isa_pkg::TRAP_NONE) ? dec_op : wasm_core_pkg::STACK_NONE;
  assign stack_data = dec_data;

  always_ff @(posedge clk) begin
    if (reset) begin
      step <= wasm_core_pkg::FETCH;
      pc   <= start_pc;
      trap <= wasm_isa_pkg::TRAP_NONE;
    end else if (trap == wasm_isa_pkg::TRAP_NONE) begin
      case (step)
        wasm_core_pkg::FETCH:  step <= wasm_core_pkg::FETCH2;
        wasm_core_pkg::FETCH2: step <= wasm_core_pkg::EXEC;
        wasm_core_pkg::EXEC: begin
          step <= wasm_core_pkg::FETCH;
          pc   <= pc + wasm_core_pkg::pc_t'(advance) + 8'd1;
          trap <= exec_trap;
        end
        default: step <= wasm_core_pkg::FETCH;
      endcase
    end
  end

  // Memory sees the address during FETCH2
  always_ff @(posedge clk) begin
    if (step == wasm_core_pkg::FETCH) begin
      rom_addr <= pc;
    end
  end

endmodule

// File: verilog/wasm_core_pkg.sv
package wasm_core_pkg;

  // Program memory
  localparam int ROM_DEPTH = 64;

  typedef logic [7:0] pc_t;
  typedef logic [7:0] rom_byte_t;

  // Opcode byte followed by the bytes that may hold its immediate
  typedef struct packed {
    rom_byte_t                                         opcode;
    rom_byte_t [wasm_isa_pkg::LEB128_MAX_BYTES-1:0]    imm;
  } rom_window_t;

  // Operand stack, i32 payloads kept zero-extended
  localparam int STACK_DEPTH = 16;

  typedef logic [63:0] value_t;
  typedef logic [4:0]  stack_count_t;

  typedef struct packed {
    wasm_isa_pkg::value_type_t tag;
    value_t                    value;
  } stack_entry_t;

  typedef enum logic [2:0] {
    STACK_NONE         = 3'd0,
    STACK_PUSH         = 3'd1,
    STACK_POP          = 3'd2,
    STACK_REPLACE      = 3'd3,
    STACK_POP1_REPLACE = 3'd4,
    STACK_POP2_REPLACE = 3'd5
  } stack_op_t;

  // One instruction every three cycles
  typedef enum logic [1:0] {
    FETCH  = 2'd0,
    FETCH2 = 2'd1,
    EXEC   = 2'd2
  } step_t;

endpackage

// File: verilog/wasm_cpu.sv
`timescale 1ns/100ps

module wasm_cpu (
  input  logic                        clk,
  input  logic                        reset,
  input  wasm_core_pkg::pc_t          start_pc,
  input  logic                        prog_we,
  input  wasm_core_pkg::pc_t          prog_addr,
  input  wasm_core_pkg::rom_byte_t    prog_data,
  output wasm_core_pkg::stack_entry_t result,
  output logic                        result_empty,
  output wasm_isa_pkg::trap_t         trap
);

  wasm_core_pkg::pc_t          rom_addr;
  wasm_core_pkg::rom_window_t  rom_window;
  logic                        rom_error;
  wasm_core_pkg::stack_op_t    stack_op;
  wasm_core_pkg::stack_entry_t stack_data;
  wasm_core_pkg::stack_entry_t stack_top;
  wasm_core_pkg::stack_entry_t stack_second;
  wasm_core_pkg::stack_entry_t stack_third;
  wasm_core_pkg::stack_count_t stack_count;

  program_rom rom_i (
    .clk       (clk),
    .prog_we   (prog_we),
    .prog_addr (prog_addr),
    .prog_data (prog_data),
    .rom_addr  (rom_addr),
    .window    (rom_window),
    .rom_error (rom_error)
  );

  value_stack stack_i (
    .clk    (clk),
    .reset  (reset),
    .op     (stack_op),
    .data   (stack_data),
    .top    (stack_top),
    .second (stack_second),
    .third  (stack_third),
    .count  (stack_count)
  );

  wasm_control control_i (
    .clk        (clk),
    .reset      (reset),
    .start_pc   (start_pc),
    .rom_addr   (rom_addr),
    .window     (rom_window),
    .rom_error  (rom_error),
    .stack_op   (stack_op),
    .stack_data (stack_data),
    .top        (stack_top),
    .second     (stack_second),
    .third      (stack_third),
    .count      (stack_count),
    .trap       (trap)
  );

  // Empty stack reads as a zero top entry
  assign result       = stack_top;
  assign result_empty = stack_count == '0;

endmodule

// File: verilog/wasm_isa_pkg.sv
package wasm_isa_pkg;

  // Longest signed LEB128 immediate for a 64-bit value
  localparam int LEB128_MAX_BYTES = 10;

  // Byte values as in the WebAssembly binary format
  typedef enum logic [7:0] {
    OP_UNREACHABLE = 8'h00,
    OP_NOP         = 8'h01,
    OP_END         = 8'h0B,
    OP_DROP        = 8'h1A,
    OP_SELECT      = 8'h1B,
    OP_I32_CONST   = 8'h41,
    OP_I64_CONST   = 8'h42,
    OP_I32_EQZ     = 8'h45,
    OP_I32_EQ      = 8'h46,
    OP_I32_NE      = 8'h47,
    OP_I64_EQZ     = 8'h50,
    OP_I64_EQ      = 8'h51,
    OP_I64_NE      = 8'h52,
    OP_I32_ADD     = 8'h6A,
    OP_I32_SUB     = 8'h6B,
    OP_I64_ADD     = 8'h7C,
    OP_I64_SUB     = 8'h7D
  } opcode_t;

  typedef enum logic [0:0] {
    I32 = 1'b0,
    I64 = 1'b1
  } value_type_t;

  // Sticky until reset, TRAP_ENDED is the normal way out
  typedef enum logic [3:0] {
    TRAP_NONE           = 4'd0,
    TRAP_ENDED          = 4'd1,
    TRAP_UNREACHABLE    = 4'd2,
    TRAP_UNKNOWN_OPCODE = 4'd3,
    TRAP_TYPE_MISMATCH  = 4'd4,
    TRAP_TYPES_MISMATCH = 4'd5,
    TRAP_STACK_EMPTY    = 4'd6,
    TRAP_STACK_FULL     = 4'd7,
    TRAP_ROM_ERROR      = 4'd8
  } trap_t;

endpackage

// File: vlog.f
verilog/wasm_isa_pkg.sv
verilog/wasm_core_pkg.sv
verilog/program_rom.sv
verilog/leb128_decoder.sv
verilog/value_stack.sv
verilog/wasm_alu.sv
verilog/wasm_control.sv
verilog/wasm_cpu.sv
test/wasm_cpu_chk.sv
test/wasm_cpu_tb.sv
